// File: verilog/io_bridge_defines.svh
`ifndef IO_BRIDGE_DEFINES_SVH
`define IO_BRIDGE_DEFINES_SVH

// **************************************************
// Bridge geometry
// **************************************************

`define IO_NUM_PORTS	16		// One port per high address nibble
`define IO_DATA_W		8
`define IO_ADDR_W		8
`define IO_SEL_W		4		// High nibble of the port address

// **************************************************
// Acknowledge timeout
// **************************************************

// Cycles a strobe may wait for ack_i in an 8-bit count
`define IO_ACK_TIMEOUT	8'd8

`endif

// File: verilog/io_bridge_pkg.sv
`default_nettype none

package io_bridge_pkg;

	// Strobe sequencing with one strobe per CPU cycle
	typedef enum logic [1:0]
	{
		ST_IDLE   = 2'd0,
		ST_STROBE = 2'd1,
		ST_HOLD   = 2'd2		// Strobe done and waiting for CPU cycle end
	} bridge_state_t;

	// Kind of CPU I/O cycle on the bus
	typedef enum logic [1:0]
	{
		OP_NONE  = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd2
	} bus_op_t;

endpackage

`default_nettype wire

// File: verilog/io_port_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "io_bridge_defines.svh"

module io_port_decode
(
	input  logic [`IO_ADDR_W-1:0]               a_i,
	input  logic [`IO_DATA_W-1:0]               d_i,
	input  logic                                nrd_i,
	input  logic                                nwr_i,
	input  logic                                niorq_i,
	input  logic [`IO_NUM_PORTS*`IO_DATA_W-1:0] io_i,
	output logic [`IO_NUM_PORTS-1:0]            port_nrd_o,
	output logic [`IO_NUM_PORTS-1:0]            port_nwr_o,
	output logic [`IO_ADDR_W-`IO_SEL_W-1:0]     port_a_o,
	output logic [`IO_DATA_W-1:0]               io_o,
	output logic [`IO_DATA_W-1:0]               d_o,
	output logic [`IO_SEL_W-1:0]                sel_o,
	output io_bridge_pkg::bus_op_t              op_o
);
	import io_bridge_pkg::*;

	logic io_nrd;
	logic io_nwr;
	logic [`IO_NUM_PORTS-1:0] sel_n;		// Active-low one-hot port select

	assign io_nrd = niorq_i | nrd_i;
	assign io_nwr = niorq_i | nwr_i;

	assign sel_o    = a_i[`IO_ADDR_W-1 -: `IO_SEL_W];
	assign port_a_o = a_i[`IO_ADDR_W-`IO_SEL_W-1:0];
	assign io_o     = d_i;

	assign sel_n = ~({{(`IO_NUM_PORTS-1){1'b0}}, 1'b1} << sel_o);

	assign port_nrd_o = io_nrd ? {`IO_NUM_PORTS{1'b1}} : sel_n;
	assign port_nwr_o = io_nwr ? {`IO_NUM_PORTS{1'b1}} : sel_n;

	// Write wins if the CPU ever drives both strobes
	always_comb
	begin
		if (!io_nwr)
			op_o = OP_WRITE;
		else if (!io_nrd)
			op_o = OP_READ;
		else
			op_o = OP_NONE;
	end

	// **************************************************
	// Read data return
	// **************************************************

	// Port 0 sits in the top byte of io_i and port 15 in the bottom byte
	always_comb
	begin
		d_o = {`IO_DATA_W{1'b1}};
		if (op_o == OP_READ)
		begin
			for (int i = 0; i < `IO_NUM_PORTS; i++)
			begin
				if (sel_o == i[`IO_SEL_W-1:0])
					d_o = io_i[(`IO_NUM_PORTS-1-i)*`IO_DATA_W +: `IO_DATA_W];
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/io_cycle_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module io_cycle_fsm
(
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   ack_i,
	input  logic                   expired_i,
	input  io_bridge_pkg::bus_op_t op_i,
	output logic                   load_o,
	output logic                   clear_o,
	output logic                   run_o,
	output logic                   timeout_o
);
	import io_bridge_pkg::*;

	bridge_state_t state;
	bridge_state_t state_nxt;
	logic cycle_on;
	logic end_strobe;
	logic expiry_only;

	assign cycle_on    = (op_i != OP_NONE);
	assign end_strobe  = ack_i | ~cycle_on | expired_i;
	assign expiry_only = expired_i & ~ack_i & cycle_on;	// Neither ack nor cycle end

	// **************************************************
	// Next state and strobe control
	// **************************************************

	always_comb
	begin
		state_nxt = state;
		load_o    = 1'b0;
		clear_o   = 1'b0;
		run_o     = 1'b0;
		case (state)
			ST_IDLE:
			begin
				if (cycle_on)
				begin
					load_o    = 1'b1;		// Strobe rises at this edge
					state_nxt = ST_STROBE;
				end
			end
			ST_STROBE:
			begin
				run_o = 1'b1;
				if (end_strobe)
				begin
					clear_o   = 1'b1;
					state_nxt = ST_HOLD;
				end
			end
			ST_HOLD:
			begin
				if (!cycle_on)
					state_nxt = ST_IDLE;
			end
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			state     <= ST_IDLE;
			timeout_o <= 1'b0;
		end
		else
		begin
			state     <= state_nxt;
			timeout_o <= (state == ST_STROBE) & expiry_only;
		end
	end

endmodule

`default_nettype wire

// File: verilog/ack_timeout.sv
`timescale 1ns/100ps
`default_nettype none

`include "io_bridge_defines.svh"

module ack_timeout
(
	input  logic clk_i,
	input  logic rst_i,
	input  logic run_i,
	output logic expired_o
);

	logic [7:0] count;		// Cycles the current strobe has waited

	// Stops at the limit so expired_o stays up until run_i drops
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			count <= 8'd0;
		else if (!run_i)
			count <= 8'd0;
		else if (count < `IO_ACK_TIMEOUT)
			count <= count + 8'd1;
	end

	assign expired_o = (count >= `IO_ACK_TIMEOUT);

endmodule

`default_nettype wire

// File: verilog/bus_latch.sv
`timescale 1ns/100ps
`default_nettype none

`include "io_bridge_defines.svh"

module bus_latch
(
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     load_i,
	input  logic                     clear_i,
	input  logic [`IO_ADDR_W-1:0]    a_i,
	input  logic [`IO_DATA_W-1:0]    d_i,
	input  logic [`IO_SEL_W-1:0]     sel_i,
	input  io_bridge_pkg::bus_op_t   op_i,
	output logic [`IO_NUM_PORTS-1:0] stb_o,
	output logic [`IO_NUM_PORTS-1:0] we_o,
	output logic [`IO_ADDR_W-1:0]    adr_o,
	output logic [`IO_DATA_W-1:0]    dat_o
);
	import io_bridge_pkg::*;

	logic [`IO_NUM_PORTS-1:0] port_hot;

	assign port_hot = {{(`IO_NUM_PORTS-1){1'b0}}, 1'b1} << sel_i;

	// **************************************************
	// Transaction registers
	// **************************************************

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			stb_o <= '0;
			we_o  <= '0;
			adr_o <= {`IO_ADDR_W{1'b1}};		// Bus reads as floating after reset
			dat_o <= {`IO_DATA_W{1'b1}};
		end
		else if (load_i)
		begin
			adr_o <= a_i;
			dat_o <= d_i;
			stb_o <= port_hot;
			we_o  <= (op_i == OP_WRITE) ? port_hot : '0;
		end
		else if (clear_i)
		begin
			stb_o <= '0;		// Address and data stay for inspection
			we_o  <= '0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/io_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "io_bridge_defines.svh"

module io_bridge_top
(
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  logic [`IO_ADDR_W-1:0]               a_i,
	input  logic [`IO_DATA_W-1:0]               d_i,
	input  logic                                nrd_i,
	input  logic                                nwr_i,
	input  logic                                niorq_i,
	output logic [`IO_DATA_W-1:0]               d_o,
	output logic [`IO_ADDR_W-`IO_SEL_W-1:0]     port_a_o,
	output logic [`IO_NUM_PORTS-1:0]            port_nrd_o,
	output logic [`IO_NUM_PORTS-1:0]            port_nwr_o,
	output logic [`IO_DATA_W-1:0]               io_o,
	input  logic [`IO_NUM_PORTS*`IO_DATA_W-1:0] io_i,
	input  logic                                ack_i,
	output logic [`IO_NUM_PORTS-1:0]            stb_o,
	output logic [`IO_NUM_PORTS-1:0]            we_o,
	output logic [`IO_ADDR_W-1:0]               adr_o,
	output logic [`IO_DATA_W-1:0]               dat_o,
	output logic                                timeout_o
);
	import io_bridge_pkg::*;

	bus_op_t op;
	logic [`IO_SEL_W-1:0] sel;
	logic load;
	logic clear;
	logic run;
	logic expired;

	io_port_decode u_decode
	(
		.a_i        (a_i),
		.d_i        (d_i),
		.nrd_i      (nrd_i),
		.nwr_i      (nwr_i),
		.niorq_i    (niorq_i),
		.io_i       (io_i),
		.port_nrd_o (port_nrd_o),
		.port_nwr_o (port_nwr_o),
		.port_a_o   (port_a_o),
		.io_o       (io_o),
		.d_o        (d_o),
		.sel_o      (sel),
		.op_o       (op)
	);

	io_cycle_fsm u_fsm
	(
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.ack_i     (ack_i),
		.expired_i (expired),
		.op_i      (op),
		.load_o    (load),
		.clear_o   (clear),
		.run_o     (run),
		.timeout_o (timeout_o)
	);

	ack_timeout u_timeout
	(
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.run_i     (run),
		.expired_o (expired)
	);

	bus_latch u_latch
	(
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.load_i  (load),
		.clear_i (clear),
		.a_i     (a_i),
		.d_i     (d_i),
		.sel_i   (sel),
		.op_i    (op),
		.stb_o   (stb_o),
		.we_o    (we_o),
		.adr_o   (adr_o),
		.dat_o   (dat_o)
	);

endmodule

`default_nettype wire

// File: verification/io_bridge_tests.svh
`ifndef IO_BRIDGE_TESTS_SVH
`define IO_BRIDGE_TESTS_SVH

// Every task starts and ends just after a falling edge

function automatic logic [`IO_NUM_PORTS-1:0] one_hot_port(input logic [`IO_ADDR_W-1:0] addr);
	logic [`IO_NUM_PORTS-1:0] hot;
	hot = '0;
	hot[addr[`IO_ADDR_W-1 -: `IO_SEL_W]] = 1'b1;
	return hot;
endfunction

// **************************************************
// CPU cycle helpers
// **************************************************

task automatic check_decode(input bus_op_t op, input logic [`IO_ADDR_W-1:0] addr,
	input logic [`IO_DATA_W-1:0] data);
	logic [`IO_NUM_PORTS-1:0] sel_n;
	sel_n = ~one_hot_port(addr);
	#1;		// Let the combinational paths settle
	check_mask("port_nrd_o", (op == OP_READ) ? sel_n : '1, port_nrd_o);
	check_mask("port_nwr_o", (op == OP_WRITE) ? sel_n : '1, port_nwr_o);
	check_nibble("port_a_o", addr[`IO_SEL_W-1:0], port_a_o);
	check_byte("io_o", data, io_o);
	check_byte("d_o", (op == OP_READ) ? port_mem[addr[`IO_ADDR_W-1 -: `IO_SEL_W]] : 8'hff, d_o);
endtask

task automatic start_cycle(input bus_op_t op, input logic [`IO_ADDR_W-1:0] addr,
	input logic [`IO_DATA_W-1:0] data, input int delay);
	ack_delay = delay;
	a_i       = addr;
	d_i       = data;
	niorq_i   = 1'b0;
	nrd_i     = (op != OP_READ);
	nwr_i     = (op != OP_WRITE);
	check_decode(op, addr, data);
	@(negedge clk_i);		// Strobe is up one edge into the cycle
	check_mask("stb_o", one_hot_port(addr), stb_o);
	check_mask("we_o", (op == OP_WRITE) ? one_hot_port(addr) : '0, we_o);
	check_byte("adr_o", addr, adr_o);
	check_byte("dat_o", data, dat_o);
endtask

task automatic wait_ack(input logic [`IO_ADDR_W-1:0] addr, input int delay);
	logic seen;
	int waited;
	seen   = 1'b0;
	waited = 0;
	while (!seen)
	begin
		@(posedge clk_i);
		seen = ack_i;
		@(negedge clk_i);
		waited++;
		if (!seen && waited > delay + 1)
		begin
			$display("Peripheral acknowledge did not arrive after %0d cycles", waited);
			abort_run();
		end
		if (!seen)
			check_mask("stb_o", one_hot_port(addr), stb_o);
	end
	check_mask("stb_o", '0, stb_o);		// Cleared at the ack edge
	check_mask("we_o", '0, we_o);
	check_flag("timeout_o", 1'b0, timeout_o);
endtask

task automatic end_cycle();
	niorq_i = 1'b1;
	nrd_i   = 1'b1;
	nwr_i   = 1'b1;
	@(negedge clk_i);
	check_mask("stb_o", '0, stb_o);
	check_mask("port_nrd_o", '1, port_nrd_o);
	check_mask("port_nwr_o", '1, port_nwr_o);
endtask

// **************************************************
// Directed tests
// **************************************************

task automatic test_idle_bus();
	check_mask("stb_o", '0, stb_o);
	check_mask("we_o", '0, we_o);
	check_byte("adr_o", 8'hff, adr_o);
	check_byte("dat_o", 8'hff, dat_o);
	check_flag("timeout_o", 1'b0, timeout_o);
	a_i   = 8'h37;		// Read and write low with niorq high
	d_i   = 8'hc5;
	nrd_i = 1'b0;
	nwr_i = 1'b0;
	check_decode(OP_NONE, 8'h37, 8'hc5);
	repeat (3) @(negedge clk_i);
	check_mask("stb_o", '0, stb_o);
	nrd_i   = 1'b1;
	nwr_i   = 1'b1;
	niorq_i = 1'b0;
	check_decode(OP_NONE, 8'h37, 8'hc5);
	repeat (3) @(negedge clk_i);
	check_mask("stb_o", '0, stb_o);
	niorq_i = 1'b1;
endtask

task automatic test_write_cycle();
	start_cycle(OP_WRITE, 8'h5a, 8'h3c, 2);
	wait_ack(8'h5a, 2);
	end_cycle();
endtask

task automatic test_read_cycle();
	start_cycle(OP_READ, 8'ha3, 8'h00, 0);
	wait_ack(8'ha3, 0);
	end_cycle();
endtask

task automatic test_timeout();
	int high;
	int pulses;
	high   = 0;
	pulses = 0;
	start_cycle(OP_WRITE, 8'h31, 8'h99, -1);
	while (stb_o != '0 && high < 4 * `IO_ACK_TIMEOUT)
	begin
		check_flag("timeout_o", 1'b0, timeout_o);
		high++;
		@(negedge clk_i);
	end
	// Expiry is seen one edge after the count reaches the limit
	check_byte("stb_o high cycles", 8'(`IO_ACK_TIMEOUT + 1), 8'(high));
	check_mask("we_o", '0, we_o);
	check_flag("timeout_o", 1'b1, timeout_o);
	repeat (5)
	begin
		if (timeout_o)
			pulses++;
		@(negedge clk_i);
	end
	check_byte("timeout_o pulses", 8'd1, 8'(pulses));
	end_cycle();
endtask

task automatic test_single_strobe();
	start_cycle(OP_WRITE, 8'h9e, 8'h42, 1);
	wait_ack(8'h9e, 1);
	repeat (20)		// CPU holds the cycle long after the ack
	begin
		@(negedge clk_i);
		check_mask("stb_o", '0, stb_o);
	end
	end_cycle();
	start_cycle(OP_READ, 8'h64, 8'h00, -1);
	repeat (2) @(negedge clk_i);
	check_mask("stb_o", one_hot_port(8'h64), stb_o);
	end_cycle();
	repeat (`IO_ACK_TIMEOUT + 2)
	begin
		check_flag("timeout_o", 1'b0, timeout_o);
		@(negedge clk_i);
	end
endtask

task automatic test_random_cycles();
	logic [31:0] rnd;
	int delay;
	repeat (NUM_RANDOM)
	begin
		rnd   = $random(seed);
		delay = int'(rnd[17:16]);
		start_cycle(rnd[24] ? OP_WRITE : OP_READ, rnd[7:0], rnd[15:8], delay);
		wait_ack(rnd[7:0], delay);
		end_cycle();
	end
endtask

`endif

// File: verification/io_bridge_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "io_bridge_defines.svh"

module io_bridge_tb;
	import io_bridge_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_RANDOM = 40;
	localparam int RUN_CYCLES = (6 + NUM_RANDOM) * 200 + 100;	// 200 per test plus margin

	logic clk_i = 1'b0;
	logic rst_i;
	logic [`IO_ADDR_W-1:0] a_i;
	logic [`IO_DATA_W-1:0] d_i;
	logic nrd_i;
	logic nwr_i;
	logic niorq_i;
	logic [`IO_NUM_PORTS*`IO_DATA_W-1:0] io_i;
	logic ack_i = 1'b0;
	logic [`IO_DATA_W-1:0] d_o;
	logic [`IO_ADDR_W-`IO_SEL_W-1:0] port_a_o;
	logic [`IO_NUM_PORTS-1:0] port_nrd_o;
	logic [`IO_NUM_PORTS-1:0] port_nwr_o;
	logic [`IO_DATA_W-1:0] io_o;
	logic [`IO_NUM_PORTS-1:0] stb_o;
	logic [`IO_NUM_PORTS-1:0] we_o;
	logic [`IO_ADDR_W-1:0] adr_o;
	logic [`IO_DATA_W-1:0] dat_o;
	logic timeout_o;

	logic [`IO_DATA_W-1:0] port_mem [`IO_NUM_PORTS];	// Peripheral read bytes
	int ack_delay = -1;		// Negative means the peripheral never answers
	int ack_wait = 0;
	integer seed;

	io_bridge_top u_io_bridge_top (.*);

	always #(CLK_PERIOD/2) clk_i = ~clk_i;

	// **************************************************
	// Peripheral model
	// **************************************************

	// Port 0 in the top byte of io_i
	for (genvar g = 0; g < `IO_NUM_PORTS; g++)
	begin : g_port
		assign io_i[(`IO_NUM_PORTS-1-g)*`IO_DATA_W +: `IO_DATA_W] = port_mem[g];
	end

	always @(negedge clk_i)
	begin
		if (rst_i || stb_o == '0)
		begin
			ack_i    = 1'b0;
			ack_wait = 0;
		end
		else if (ack_delay >= 0 && !ack_i)
		begin
			if (ack_wait == ack_delay)
				ack_i = 1'b1;		// Held for one cycle while the strobe drops on it
			else
				ack_wait++;
		end
	end

	// **************************************************
	// Compare tasks
	// **************************************************

	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_byte(input string name, input logic [`IO_DATA_W-1:0] exp,
		input logic [`IO_DATA_W-1:0] act);
		if (act !== exp)
		begin
			$display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_nibble(input string name, input logic [`IO_SEL_W-1:0] exp,
		input logic [`IO_SEL_W-1:0] act);
		if (act !== exp)
		begin
			$display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_mask(input string name, input logic [`IO_NUM_PORTS-1:0] exp,
		input logic [`IO_NUM_PORTS-1:0] act);
		if (act !== exp)
		begin
			$display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("** Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	`include "io_bridge_tests.svh"

	// **************************************************
	// Test sequence
	// **************************************************

	initial
	begin
		logic [31:0] rnd;
		seed    = 32'h22d7_ac34;
		rst_i   = 1'b1;
		a_i     = '0;
		d_i     = '0;
		nrd_i   = 1'b1;
		nwr_i   = 1'b1;
		niorq_i = 1'b1;
		for (int i = 0; i < `IO_NUM_PORTS; i++)
		begin
			rnd = $random(seed);
			port_mem[i[`IO_SEL_W-1:0]] = rnd[`IO_DATA_W-1:0];
		end
		repeat (2) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;

		test_idle_bus();
		test_write_cycle();
		test_read_cycle();
		test_timeout();
		test_single_strobe();
		test_random_cycles();

		$display("NO ERRORS");
		$finish;
	end

	initial
	begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("Run timed out after %0d clock cycles", RUN_CYCLES);
		$display("ERRORS FOUND");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
+incdir+verification
verilog/io_bridge_pkg.sv
verilog/io_port_decode.sv
verilog/io_cycle_fsm.sv
verilog/ack_timeout.sv
verilog/bus_latch.sv
verilog/io_bridge_top.sv
verification/io_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the I/O bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
	--top-module io_bridge_tb -f verilog.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vio_bridge_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished cleanly"
exit 0
